// ==== compile.f ====
+incdir+src
src/tile_bus_pkg.sv
src/tile_map_pkg.sv
src/wb_if.sv
src/tile_bus.sv
src/tile_sram.sv
src/tile_bootrom.sv
src/tile_mailbox.sv
src/compute_tile.sv
sim/tb_compute_tile.sv

// ==== sim/tb_compute_tile.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module tb_compute_tile;

   localparam int SEED       = 47531;
   localparam int MAX_CYCLES = 20000;              // ~600 transfers of under 8 cycles, 4x margin

   logic                                    clk;
   logic                                    reset_i;
   logic [`TILE_MASTERS-1:0]                m_cyc_i;
   logic [`TILE_MASTERS-1:0]                m_stb_i;
   logic [`TILE_MASTERS-1:0]                m_we_i;
   tile_bus_pkg::addr_t [`TILE_MASTERS-1:0] m_adr_i;
   tile_bus_pkg::data_t [`TILE_MASTERS-1:0] m_dat_i;
   tile_bus_pkg::sel_t  [`TILE_MASTERS-1:0] m_sel_i;
   tile_bus_pkg::data_t [`TILE_MASTERS-1:0] m_dat_o;
   logic [`TILE_MASTERS-1:0]                m_ack_o;
   logic [`TILE_MASTERS-1:0]                m_err_o;
   logic                                    msg_irq_o;
   tile_bus_pkg::data_t                     lmem_model [`LMEM_WORDS];  // Byte lane SRAM model
   int                                      other_resp [`TILE_MASTERS]; // Grants lost while waiting
   int                                      cycle_cnt = 0;

   compute_tile dut0 (.clk(clk), .reset_i(reset_i), .m_cyc_i(m_cyc_i), .m_stb_i(m_stb_i),
      .m_we_i(m_we_i), .m_adr_i(m_adr_i), .m_dat_i(m_dat_i), .m_sel_i(m_sel_i),
      .m_dat_o(m_dat_o), .m_ack_o(m_ack_o), .m_err_o(m_err_o), .msg_irq_o(msg_irq_o));

   always #4 clk = ~clk;                           // 8 ns period

   task automatic report_error(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1, "Run stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES)
         report_error("Timeout: the tests did not finish within the cycle limit");
   end

   // One classic cycle, request held until ack or err
   task automatic bus_xfer(input int m, input logic we, input tile_bus_pkg::addr_t adr,
         input tile_bus_pkg::data_t dat, input tile_bus_pkg::sel_t sel,
         output logic ack, output logic err, output tile_bus_pkg::data_t rdat);
      @(negedge clk);
      assert (!(m_ack_o[m] || m_err_o[m]))
      else report_error($sformatf("Master %0d got a response with no request outstanding", m));
      m_cyc_i[m] = 1'b1;
      m_stb_i[m] = 1'b1;
      m_we_i[m]  = we;
      m_adr_i[m] = adr;
      m_dat_i[m] = dat;
      m_sel_i[m] = sel;
      other_resp[m] = 0;
      do begin
         @(negedge clk);
         if (m_ack_o[1-m] || m_err_o[1-m])
            other_resp[m]++;                       // Other master served first
      end while (!(m_ack_o[m] || m_err_o[m]));
      ack  = m_ack_o[m];
      err  = m_err_o[m];
      rdat = m_dat_o[m];
      m_cyc_i[m] = 1'b0;
      m_stb_i[m] = 1'b0;
      m_we_i[m]  = 1'b0;
   endtask

   task automatic check_data(input string name, input tile_bus_pkg::data_t got,
         input tile_bus_pkg::data_t exp);
      assert (got === exp)
      else report_error($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
   endtask

   task automatic check_resp(input string what, input logic ack, input logic err,
         input logic want_ack);
      assert (ack === want_ack && err === !want_ack)
      else report_error($sformatf("%s answered with the wrong response kind (ack %0b, err %0b)",
         what, ack, err));
   endtask

   function automatic tile_bus_pkg::data_t merge_lanes(input tile_bus_pkg::data_t old,
         input tile_bus_pkg::data_t dat, input tile_bus_pkg::sel_t sel);
      tile_bus_pkg::data_t res;
      res = old;
      for (int b = 0; b < `TILE_SELW; b++)
         if (sel[b]) res[8*b +: 8] = dat[8*b +: 8];
      return res;
   endfunction

   task automatic test_sram();
      tile_bus_pkg::addr_t addrs [$];
      tile_bus_pkg::addr_t adr;
      tile_bus_pkg::data_t dat;
      tile_bus_pkg::data_t rdat;
      tile_bus_pkg::sel_t  sel;
      logic                ack;
      logic                err;
      for (int k = 0; k < 128; k++) begin
         adr = $urandom & 32'h7FFF_FFFC;           // Anywhere below 2 GiB, wraps at 1 KiB
         dat = $urandom;
         sel = tile_bus_pkg::sel_t'($urandom);
         bus_xfer(0, 1'b1, adr, dat, sel, ack, err, rdat);
         check_resp("SRAM write", ack, err, 1'b1);
         lmem_model[adr[9:2]] = merge_lanes(lmem_model[adr[9:2]], dat, sel);
         addrs.push_back(adr);
      end
      foreach (addrs[k]) begin
         adr = (k % 2) ? (addrs[k] ^ 32'h0000_0400) : addrs[k];  // Odd reads use an alias
         bus_xfer(1, 1'b0, adr, '0, 4'hF, ack, err, rdat);
         check_resp("SRAM read", ack, err, 1'b1);
         check_data("m_dat_o[1]", rdat, lmem_model[adr[9:2]]);
      end
   endtask

   task automatic test_rom();
      tile_bus_pkg::data_t rdat;
      logic                ack;
      logic                err;
      for (int i = 0; i <= 20; i++) begin
         bus_xfer(0, 1'b0, 32'hF000_0000 | (i * 4), '0, 4'hF, ack, err, rdat);
         check_resp("ROM read", ack, err, 1'b1);
         check_data("m_dat_o[0]", rdat, {`ROM_SIG, 16'(i % `ROM_WORDS)});
      end
      bus_xfer(1, 1'b1, 32'hF000_0008, $urandom, 4'hF, ack, err, rdat);
      check_resp("ROM write", ack, err, 1'b0);
      bus_xfer(1, 1'b0, 32'hF000_0008, '0, 4'hF, ack, err, rdat);
      check_resp("ROM read after write", ack, err, 1'b1);
      check_data("m_dat_o[1]", rdat, {`ROM_SIG, 16'd2});
   endtask

   task automatic test_mailbox();
      tile_bus_pkg::data_t words [`MBOX_DEPTH];
      tile_bus_pkg::data_t rdat;
      logic                ack;
      logic                err;
      check_data("msg_irq_o", 32'(msg_irq_o), 32'd0);
      for (int k = 0; k < `MBOX_DEPTH; k++) begin
         words[k] = $urandom;
         bus_xfer(k % 2, 1'b1, 32'hE000_0000, words[k], 4'hF, ack, err, rdat);
         check_resp("Mailbox push", ack, err, 1'b1);
      end
      bus_xfer(0, 1'b1, 32'hE000_0000, $urandom, 4'hF, ack, err, rdat);
      check_resp("Mailbox push when full", ack, err, 1'b0);
      bus_xfer(1, 1'b0, 32'hE000_0004, '0, 4'hF, ack, err, rdat);
      check_resp("Mailbox status read", ack, err, 1'b1);
      check_data("m_dat_o[1]", rdat, `MBOX_DEPTH);
      check_data("msg_irq_o", 32'(msg_irq_o), 32'd1);
      for (int k = 0; k < `MBOX_DEPTH; k++) begin
         bus_xfer(k % 2, 1'b0, 32'hE000_0000, '0, 4'hF, ack, err, rdat);
         check_resp("Mailbox pop", ack, err, 1'b1);
         check_data($sformatf("m_dat_o[%0d]", k % 2), rdat, words[k]);
      end
      bus_xfer(0, 1'b0, 32'hE000_0000, '0, 4'hF, ack, err, rdat);
      check_resp("Mailbox pop when empty", ack, err, 1'b0);
      check_data("msg_irq_o", 32'(msg_irq_o), 32'd0);
   endtask

   task automatic test_unmapped();
      tile_bus_pkg::addr_t adr;
      tile_bus_pkg::data_t rdat;
      logic                ack;
      logic                err;
      for (int n = 8; n <= 13; n++) begin
         adr = {4'(n), 28'($urandom)} & 32'hFFFF_FFFC;
         bus_xfer(n % 2, 1'($urandom), adr, $urandom, 4'hF, ack, err, rdat);
         check_resp("Unmapped access", ack, err, 1'b0);
      end
      bus_xfer(0, 1'b1, 32'hE000_0004, $urandom, 4'hF, ack, err, rdat);
      check_resp("Mailbox status write", ack, err, 1'b0);
   endtask

   // Back to back SRAM accesses of one master while the other one competes
   task automatic contend_burst(input int m, input int n);
      logic                we;
      int                  w;
      tile_bus_pkg::data_t dat;
      tile_bus_pkg::sel_t  sel;
      tile_bus_pkg::data_t rdat;
      logic                ack;
      logic                err;
      repeat (n) begin
         we  = 1'($urandom);
         w   = ($urandom % (`LMEM_WORDS / 2)) * 2 + m;  // Master 0 even, master 1 odd words
         dat = $urandom;
         sel = tile_bus_pkg::sel_t'($urandom);
         bus_xfer(m, we, 32'(w * 4), dat, sel, ack, err, rdat);
         check_resp("Contended SRAM access", ack, err, 1'b1);
         assert (other_resp[m] <= 2)
         else report_error($sformatf("Master %0d waited through too many grants", m));
         if (we)
            lmem_model[w] = merge_lanes(lmem_model[w], dat, sel);
         else
            check_data($sformatf("m_dat_o[%0d]", m), rdat, lmem_model[w]);
      end
      @(negedge clk);
      assert (!m_ack_o[m] && !m_err_o[m])
      else report_error($sformatf("Master %0d got a second response to a single request", m));
   endtask

   task automatic test_contention();
      for (int it = 0; it < 32; it++) begin
         fork
            contend_burst(0, 3);
            contend_burst(1, 3);
         join
      end
   endtask

   initial begin
      void'($urandom(SEED));
      clk     = 1'b0;
      reset_i = 1'b1;
      m_cyc_i = '0;
      m_stb_i = '0;
      m_we_i  = '0;
      m_adr_i = '0;
      m_dat_i = '0;
      m_sel_i = '0;
      foreach (lmem_model[i]) lmem_model[i] = '0;  // SRAM powers up cleared
      repeat (5) @(negedge clk);
      reset_i = 1'b0;
      test_mailbox();
      test_sram();
      test_rom();
      test_unmapped();
      test_contention();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== src/compute_tile.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module compute_tile (
   input  logic                                    clk,
   input  logic                                    reset_i,
   input  logic [`TILE_MASTERS-1:0]                m_cyc_i,
   input  logic [`TILE_MASTERS-1:0]                m_stb_i,
   input  logic [`TILE_MASTERS-1:0]                m_we_i,
   input  tile_bus_pkg::addr_t [`TILE_MASTERS-1:0] m_adr_i,
   input  tile_bus_pkg::data_t [`TILE_MASTERS-1:0] m_dat_i,
   input  tile_bus_pkg::sel_t  [`TILE_MASTERS-1:0] m_sel_i,
   output tile_bus_pkg::data_t [`TILE_MASTERS-1:0] m_dat_o,
   output logic [`TILE_MASTERS-1:0]                m_ack_o,
   output logic [`TILE_MASTERS-1:0]                m_err_o,
   output logic                                    msg_irq_o
);

   wb_if mst_bus [`TILE_MASTERS] ();                // Core data and debug master
   wb_if lmem_bus ();
   wb_if msg_bus ();
   wb_if rom_bus ();

   for (genvar i = 0; i < `TILE_MASTERS; i++) begin : g_port
      assign mst_bus[i].cyc   = m_cyc_i[i];
      assign mst_bus[i].stb   = m_stb_i[i];
      assign mst_bus[i].we    = m_we_i[i];
      assign mst_bus[i].adr   = m_adr_i[i];
      assign mst_bus[i].dat_w = m_dat_i[i];
      assign mst_bus[i].sel   = m_sel_i[i];
      assign m_dat_o[i]       = mst_bus[i].dat_r;
      assign m_ack_o[i]       = mst_bus[i].ack;
      assign m_err_o[i]       = mst_bus[i].err;
   end

   tile_bus u_bus (
      .clk     (clk),
      .reset_i (reset_i),
      .mst     (mst_bus),
      .lmem    (lmem_bus),
      .msg     (msg_bus),
      .rom     (rom_bus)
   );

   tile_sram u_lmem (.clk(clk), .reset_i(reset_i), .bus(lmem_bus));

   tile_bootrom u_bootrom (.clk(clk), .reset_i(reset_i), .bus(rom_bus));

   tile_mailbox u_mbox (.clk(clk), .reset_i(reset_i), .bus(msg_bus), .irq_o(msg_irq_o));

endmodule

// ==== src/tile_mailbox.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_mailbox (
   input  logic clk,
   input  logic reset_i,
   wb_if.slave  bus,
   output logic irq_o
);

   localparam int PW = $clog2(`MBOX_DEPTH);
   localparam int CW = $clog2(`MBOX_DEPTH + 1);

   tile_bus_pkg::data_t      fifo [`MBOX_DEPTH];
   tile_bus_pkg::tile_addr_u a;
   logic [25:0]              word_ofs;             // Word offset in the window
   logic [PW-1:0]            wr_ptr_q;
   logic [PW-1:0]            rd_ptr_q;
   logic [CW-1:0]            count_q;
   logic                     valid;
   logic                     is_data;
   logic                     push;
   logic                     pop;
   logic                     stat_rd;
   logic                     ack_q;
   logic                     err_q;
   tile_bus_pkg::data_t      dat_q;

   assign a        = bus.adr;
   assign word_ofs = a.dev.offset[27:2];
   assign valid    = bus.cyc & bus.stb & ~(ack_q | err_q);
   assign is_data  = (word_ofs == tile_map_pkg::MBOX_DATA_OFS);
   assign push     = valid & is_data & bus.we & (count_q != CW'(`MBOX_DEPTH));
   assign pop      = valid & is_data & ~bus.we & (count_q != '0);
   assign stat_rd  = valid & ~bus.we & (word_ofs == tile_map_pkg::MBOX_STAT_OFS);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         ack_q    <= 1'b0;
         err_q    <= 1'b0;
      end else begin
         if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push) count_q <= count_q + 1'b1;
         else if (pop) count_q <= count_q - 1'b1;
         ack_q <= push | pop | stat_rd;
         err_q <= valid & ~(push | pop | stat_rd);  // Full, empty or bad register
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         fifo[wr_ptr_q] <= bus.dat_w;
      if (valid)
         dat_q <= stat_rd ? tile_bus_pkg::data_t'(count_q) : fifo[rd_ptr_q];
   end

   assign bus.ack   = ack_q;
   assign bus.err   = err_q;
   assign bus.dat_r = dat_q;
   assign irq_o     = (count_q != '0);              // Pending message

   a_count_bound: assert property (@(posedge clk) disable iff (reset_i)
      count_q <= CW'(`MBOX_DEPTH));

endmodule

// ==== src/tile_bootrom.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_bootrom (
   input logic clk,
   input logic reset_i,
   wb_if.slave bus
);

   localparam int RW = $clog2(`ROM_WORDS);

   tile_bus_pkg::tile_addr_u a;
   logic [RW-1:0]            idx;
   logic                     valid;
   logic                     ack_q;
   logic                     err_q;
   tile_bus_pkg::data_t      dat_q;

   assign a     = bus.adr;
   assign idx   = a.mem.word[RW-1:0];              // Index modulo ROM size
   assign valid = bus.cyc & bus.stb & ~(ack_q | err_q);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= valid & ~bus.we;
         err_q <= valid & bus.we;                  // Writes are refused
      end
   end

   always_ff @(posedge clk) begin
      if (valid)
         dat_q <= {`ROM_SIG, 16'(idx)};
   end

   assign bus.ack   = ack_q;
   assign bus.err   = err_q;
   assign bus.dat_r = dat_q;

endmodule

// ==== src/tile_sram.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_sram (
   input logic clk,
   input logic reset_i,
   wb_if.slave bus
);

   localparam int IW = $clog2(`LMEM_WORDS);

   tile_bus_pkg::data_t      mem [`LMEM_WORDS] = '{default: '0};  // Starts cleared
   tile_bus_pkg::tile_addr_u a;
   logic [IW-1:0]            idx;
   logic                     valid;
   logic                     ack_q;
   tile_bus_pkg::data_t      dat_q;

   assign a     = bus.adr;
   assign idx   = a.mem.word[IW-1:0];              // Wraps at the SRAM size
   assign valid = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= valid;                           // Zero wait states
   end

   always_ff @(posedge clk) begin
      if (valid && bus.we) begin
         for (int b = 0; b < `TILE_SELW; b++) begin
            if (bus.sel[b])
               mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
         end
      end
      if (valid)
         dat_q <= mem[idx];
   end

   assign bus.ack   = ack_q;
   assign bus.err   = 1'b0;
   assign bus.dat_r = dat_q;

   a_ack_after_stb: assert property (@(posedge clk) disable iff (reset_i)
      bus.ack |-> $past(bus.cyc && bus.stb));

endmodule

// ==== src/tile_bus.sv ====
`timescale 1ns/1ps
`include "tile_consts.svh"

module tile_bus (
   input logic clk,
   input logic reset_i,
   wb_if.slave  mst [`TILE_MASTERS],
   wb_if.master lmem,
   wb_if.master msg,
   wb_if.master rom
);

   logic [`TILE_MASTERS-1:0] cyc_m;
   logic [`TILE_MASTERS-1:0] stb_m;
   logic [`TILE_MASTERS-1:0] we_m;
   logic [`TILE_MASTERS-1:0] req;
   tile_bus_pkg::addr_t      adr_m [`TILE_MASTERS];
   tile_bus_pkg::data_t      dat_m [`TILE_MASTERS];
   tile_bus_pkg::sel_t       sel_m [`TILE_MASTERS];

   logic                     gnt_valid_q;
   logic                     gnt_q;        // Granted master, or the last one granted
   logic                     g_stb;
   tile_bus_pkg::tile_addr_u g_adr;
   tile_map_pkg::slave_e     slv;
   logic                     err_q;        // Error for unmapped addresses
   logic                     resp_ack;
   logic                     resp_err;
   tile_bus_pkg::data_t      resp_dat;

   // Round robin grant, released after the response cycle
   always_ff @(posedge clk) begin
      if (reset_i) begin
         gnt_valid_q <= 1'b0;
         gnt_q       <= 1'b1;              // Master 0 wins the first tie
      end else if (!gnt_valid_q) begin
         gnt_valid_q <= |req;
         if (req[0] && req[1])
            gnt_q <= ~gnt_q;
         else if (|req)
            gnt_q <= req[1];
      end else if (resp_ack || resp_err) begin
         gnt_valid_q <= 1'b0;
      end
   end

   assign g_stb = gnt_valid_q & stb_m[gnt_q] & cyc_m[gnt_q];
   assign g_adr = adr_m[gnt_q];

   always_comb begin
      if (!g_adr.mem.sel)
         slv = tile_map_pkg::SLV_LMEM;
      else if (g_adr.dev.region == `REGION_MSG)
         slv = tile_map_pkg::SLV_MSG;
      else if (g_adr.dev.region == `REGION_ROM)
         slv = tile_map_pkg::SLV_ROM;
      else
         slv = tile_map_pkg::SLV_NONE;
   end

   always_ff @(posedge clk) begin
      if (reset_i)
         err_q <= 1'b0;
      else
         err_q <= g_stb & (slv == tile_map_pkg::SLV_NONE) & ~err_q;  // One cycle pulse
   end

   // Request fan out, only the decoded slave sees cyc and stb
   assign lmem.cyc   = gnt_valid_q & cyc_m[gnt_q] & (slv == tile_map_pkg::SLV_LMEM);
   assign lmem.stb   = gnt_valid_q & stb_m[gnt_q] & (slv == tile_map_pkg::SLV_LMEM);
   assign lmem.we    = we_m[gnt_q];
   assign lmem.adr   = g_adr;
   assign lmem.dat_w = dat_m[gnt_q];
   assign lmem.sel   = sel_m[gnt_q];

   assign msg.cyc    = gnt_valid_q & cyc_m[gnt_q] & (slv == tile_map_pkg::SLV_MSG);
   assign msg.stb    = gnt_valid_q & stb_m[gnt_q] & (slv == tile_map_pkg::SLV_MSG);
   assign msg.we     = we_m[gnt_q];
   assign msg.adr    = g_adr;
   assign msg.dat_w  = dat_m[gnt_q];
   assign msg.sel    = sel_m[gnt_q];

   assign rom.cyc    = gnt_valid_q & cyc_m[gnt_q] & (slv == tile_map_pkg::SLV_ROM);
   assign rom.stb    = gnt_valid_q & stb_m[gnt_q] & (slv == tile_map_pkg::SLV_ROM);
   assign rom.we     = we_m[gnt_q];
   assign rom.adr    = g_adr;
   assign rom.dat_w  = dat_m[gnt_q];
   assign rom.sel    = sel_m[gnt_q];

   always_comb begin
      unique case (slv)
         tile_map_pkg::SLV_LMEM: {resp_ack, resp_err, resp_dat} = {lmem.ack, lmem.err, lmem.dat_r};
         tile_map_pkg::SLV_MSG:  {resp_ack, resp_err, resp_dat} = {msg.ack, msg.err, msg.dat_r};
         tile_map_pkg::SLV_ROM:  {resp_ack, resp_err, resp_dat} = {rom.ack, rom.err, rom.dat_r};
         default:                {resp_ack, resp_err, resp_dat} = {1'b0, err_q, 32'h0};
      endcase
   end

   for (genvar i = 0; i < `TILE_MASTERS; i++) begin : g_mst
      assign cyc_m[i] = mst[i].cyc;
      assign stb_m[i] = mst[i].stb;
      assign we_m[i]  = mst[i].we;
      assign adr_m[i] = mst[i].adr;
      assign dat_m[i] = mst[i].dat_w;
      assign sel_m[i] = mst[i].sel;
      assign req[i]   = mst[i].cyc & mst[i].stb;

      assign mst[i].ack   = gnt_valid_q & (gnt_q == i) & resp_ack;
      assign mst[i].err   = gnt_valid_q & (gnt_q == i) & resp_err;
      assign mst[i].dat_r = resp_dat;

      // A response comes only after a full cycle of grant to that master
      a_resp_granted: assert property (@(posedge clk) disable iff (reset_i)
         (mst[i].ack || mst[i].err) |-> $past(gnt_valid_q && (gnt_q == i)));

      // Slaves and the bus error path never answer together
      a_ack_err_excl: assert property (@(posedge clk) disable iff (reset_i)
         !(mst[i].ack && mst[i].err));
   end

endmodule

// ==== src/wb_if.sv ====
`timescale 1ns/1ps

interface wb_if;

   logic                cyc;
   logic                stb;
   logic                we;
   tile_bus_pkg::addr_t adr;
   tile_bus_pkg::data_t dat_w;              // Write data, master to slave
   tile_bus_pkg::sel_t  sel;
   tile_bus_pkg::data_t dat_r;              // Read data, slave to master
   logic                ack;
   logic                err;

   modport master (
      output cyc, stb, we, adr, dat_w, sel,
      input  dat_r, ack, err
   );

   modport slave (
      input  cyc, stb, we, adr, dat_w, sel,
      output dat_r, ack, err
   );

endinterface

// ==== src/tile_map_pkg.sv ====
package tile_map_pkg;

   // Slave selected by the address decoder
   typedef enum logic [1:0] {
      SLV_LMEM = 2'd0,                       // Local SRAM
      SLV_MSG  = 2'd1,                       // Message window
      SLV_ROM  = 2'd2,                       // Boot ROM
      SLV_NONE = 2'd3                        // Unmapped, bus errors
   } slave_e;

   // Mailbox register word offsets inside the message window
   localparam int unsigned MBOX_DATA_OFS = 0;  // Push on write, pop on read
   localparam int unsigned MBOX_STAT_OFS = 1;  // Fill count, read only

endpackage

// ==== src/tile_bus_pkg.sv ====
`include "tile_consts.svh"

package tile_bus_pkg;

   typedef logic [`TILE_DW-1:0]   data_t;   // One bus word
   typedef logic [`TILE_AW-1:0]   addr_t;   // Byte address
   typedef logic [`TILE_SELW-1:0] sel_t;    // Byte lane enables

   // Memory view of an address word, bit 31 picks SRAM or devices
   typedef struct packed {
      logic        sel;                      // 0 means local SRAM
      logic [28:0] word;                     // Word index
      logic [1:0]  boff;                     // Byte offset in word
   } mem_addr_t;

   // Device view of the same word
   typedef struct packed {
      logic [3:0]  region;                   // Top nibble region code
      logic [27:0] offset;                   // Byte offset in region
   } dev_addr_t;

   typedef union packed {
      mem_addr_t mem;
      dev_addr_t dev;
   } tile_addr_u;

endpackage

// ==== src/tile_consts.svh ====
`ifndef TILE_CONSTS_SVH
`define TILE_CONSTS_SVH

// Bus geometry
`define TILE_DW       32
`define TILE_AW       32
`define TILE_SELW     4
`define TILE_MASTERS  2

// Local SRAM depth in words, wraps at 1 KiB
`define LMEM_WORDS    256

// Boot ROM, word i reads as {ROM_SIG, i}
`define ROM_WORDS     16
`define ROM_SIG       16'hB007

// Receive mailbox FIFO depth
`define MBOX_DEPTH    4

// Top address nibble of the device regions
`define REGION_MSG    4'hE
`define REGION_ROM    4'hF

`endif
